/* verilog/fetch_pkg.sv */
package fetch_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// widths with a meaning
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [31:0] addr_t;     // byte address.
	typedef logic [31:0] inst_t;     // one instruction word.
	typedef logic [7:0]  imem_idx_t; // memory word index, taken from address bits 9:2.

	localparam addr_t PC_STEP    = 32'd4;         // one word per fetch.
	localparam int    IMEM_WORDS = 256;           // depth, higher addresses wrap.
	localparam inst_t NOP_INST   = 32'h0000_0000; // all zero word.
	localparam inst_t TRAP_INST  = 32'h0340_d809; // jalr into the handler.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// bundles
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef struct packed {
		logic  branch; // taken branch strobe.
		logic  jump;   // jump strobe.
		addr_t b_addr; // branch target.
		addr_t j_addr; // jump target.
	} redirect_t;

	typedef struct packed {
		addr_t pc;   // address of the word below.
		inst_t inst; // word handed to decode.
	} fetch_out_t;

	// next program counter source.
	typedef enum logic [2:0] {
		PC_SEQ, PC_BRANCH, PC_JUMP, PC_VECTOR, PC_HOLD
	} pc_sel_t;

	// what the decode latch takes on the edge.
	typedef enum logic [2:0] {
		LAT_LOAD, LAT_HOLD, LAT_BUBBLE, LAT_TRAP, LAT_NOP
	} latch_sel_t;

endpackage

/* verilog/intr_pkg.sv */
package intr_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// interrupt lines and vectors
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int IRQ_LINES = 4; // number of request lines.

	typedef logic [IRQ_LINES-1:0] irq_t; // one bit per line.

	localparam fetch_pkg::addr_t VECTOR_BASE   = 32'h0000_0100; // handler of line 0.
	localparam fetch_pkg::addr_t VECTOR_STRIDE = 32'd16;        // room per handler.

	typedef struct packed {
		logic             req;    // a line is pending and enabled.
		fetch_pkg::addr_t vector; // handler entry of that line.
	} intr_req_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// injection sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// IDLE    no injection in progress.
	// WAIT    one cycle so the delay slot drains.
	// INJECT  trap word is in the latch.
	// NOPSLOT nop word is in the latch.
	typedef enum logic [1:0] {
		IDLE, WAIT, INJECT, NOPSLOT
	} int_state_t;

endpackage

/* verilog/fetch_control.sv */
`timescale 1ns/1ns

module fetch_control (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  cpu_stall,
	input  logic                  stall,
	input  fetch_pkg::redirect_t  redirect,
	input  intr_pkg::intr_req_t   intr_req,
	output fetch_pkg::pc_sel_t    pc_sel,
	output fetch_pkg::latch_sel_t latch_sel,
	output logic                  int_ack,
	output logic                  int_flush
);

	intr_pkg::int_state_t state;      // injection state.
	intr_pkg::int_state_t state_next; // state after this edge.
	logic                 redirect_any; // branch or jump this cycle.

	assign redirect_any = redirect.branch | redirect.jump;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// injection state machine
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		state_next = state; // stay by default.
		case (state)
			intr_pkg::IDLE: begin
				if (intr_req.req) begin
					// a redirect now means its delay slot is still in flight.
					state_next = redirect_any ? intr_pkg::WAIT : intr_pkg::INJECT;
				end
			end
			intr_pkg::WAIT:    state_next = intr_pkg::INJECT;  // slot has drained.
			intr_pkg::INJECT:  state_next = intr_pkg::NOPSLOT; // nop follows trap.
			intr_pkg::NOPSLOT: state_next = intr_pkg::IDLE;    // handler fetch runs.
			default:           state_next = intr_pkg::IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!cpu_stall) begin // frozen edges change nothing.
			if (rst) begin
				state <= intr_pkg::IDLE;
			end else begin
				state <= state_next;
			end
		end
	end

	assign int_ack   = (state != intr_pkg::IDLE);        // busy with an injection.
	assign int_flush = (state_next == intr_pkg::INJECT); // pulse on the entry cycle.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// sequencer and latch selects
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		if (int_flush) begin
			pc_sel    = fetch_pkg::PC_VECTOR; // go to the handler.
			latch_sel = fetch_pkg::LAT_TRAP;  // trap word to decode.
		end else if (state == intr_pkg::INJECT) begin
			pc_sel    = fetch_pkg::PC_HOLD;   // vector stays in pc.
			latch_sel = fetch_pkg::LAT_NOP;   // fill the trap's delay slot.
		end else if (stall && !redirect_any) begin
			pc_sel    = fetch_pkg::PC_HOLD;   // decode is busy.
			latch_sel = fetch_pkg::LAT_HOLD;
		end else if (redirect_any) begin
			// branch has priority over jump.
			pc_sel    = redirect.branch ? fetch_pkg::PC_BRANCH : fetch_pkg::PC_JUMP;
			latch_sel = fetch_pkg::LAT_BUBBLE; // squash the wrong path word.
		end else begin
			pc_sel    = fetch_pkg::PC_SEQ;    // plain advance.
			latch_sel = fetch_pkg::LAT_LOAD;
		end
	end

endmodule

/* verilog/pc_sequencer.sv */
`timescale 1ns/1ns

module pc_sequencer (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 cpu_stall,
	input  fetch_pkg::pc_sel_t   pc_sel,
	input  fetch_pkg::redirect_t redirect,
	input  fetch_pkg::addr_t     vector,
	output fetch_pkg::addr_t     pc
);

	fetch_pkg::addr_t pc_next; // address loaded on the edge.
	fetch_pkg::addr_t pc_seq;  // next word in order.

	assign pc_seq = pc + fetch_pkg::PC_STEP; // wraps at the top of the space.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// next address choice
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		case (pc_sel)
			fetch_pkg::PC_SEQ:    pc_next = pc_seq;
			fetch_pkg::PC_BRANCH: pc_next = redirect.b_addr; // taken branch.
			fetch_pkg::PC_JUMP:   pc_next = redirect.j_addr; // jump target.
			fetch_pkg::PC_VECTOR: pc_next = vector;          // interrupt handler.
			fetch_pkg::PC_HOLD:   pc_next = pc;              // keep current.
			default:              pc_next = pc;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// program counter register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!cpu_stall) begin // whole cpu frozen otherwise.
			if (rst) begin
				pc <= '0; // fetch starts at address zero.
			end else begin
				pc <= pc_next;
			end
		end
	end

	// the memory reads at pc in the same cycle, so the word is ready
	// for the latch on the edge that loads pc_next.

endmodule

/* verilog/fetch_latch.sv */
`timescale 1ns/1ns

module fetch_latch (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  cpu_stall,
	input  fetch_pkg::latch_sel_t latch_sel,
	input  fetch_pkg::addr_t      pc,
	input  fetch_pkg::inst_t      inst,
	output fetch_pkg::fetch_out_t fetch_out
);

	fetch_pkg::fetch_out_t latch_next; // value taken on the edge.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// latch source
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		latch_next = fetch_out; // hold unless told otherwise.
		case (latch_sel)
			fetch_pkg::LAT_LOAD: begin
				latch_next.pc   = pc;   // pair fetched this cycle.
				latch_next.inst = inst;
			end
			fetch_pkg::LAT_BUBBLE: begin
				latch_next = '0; // squashed slot looks like a nop at pc 0.
			end
			fetch_pkg::LAT_TRAP: begin
				latch_next.pc   = '0;
				latch_next.inst = fetch_pkg::TRAP_INST; // injected jalr.
			end
			fetch_pkg::LAT_NOP: begin
				latch_next.pc   = '0;
				latch_next.inst = fetch_pkg::NOP_INST; // trap delay slot.
			end
			default: latch_next = fetch_out; // LAT_HOLD.
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// fetch to decode register
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!cpu_stall) begin
			if (rst) begin
				fetch_out <= '0; // pc 0 with a nop word.
			end else begin
				fetch_out <= latch_next;
			end
		end
	end

endmodule

/* verilog/inst_memory.sv */
`timescale 1ns/1ns

module inst_memory (
	input  logic                clk,
	input  logic                we,
	input  fetch_pkg::imem_idx_t waddr,
	input  fetch_pkg::inst_t    wdata,
	input  fetch_pkg::addr_t    pc,
	output fetch_pkg::inst_t    inst
);

	localparam int IDX_W = $bits(fetch_pkg::imem_idx_t); // index bits above the byte offset.

	fetch_pkg::inst_t    mem [fetch_pkg::IMEM_WORDS]; // program storage.
	fetch_pkg::imem_idx_t ridx;                       // word read this cycle.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// load port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// writes ignore cpu_stall so the program can go in while the core is frozen.
	always_ff @(posedge clk) begin
		if (we) begin
			mem[waddr] <= wdata; // one word per edge.
		end
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// fetch port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign ridx = pc[IDX_W+1:2]; // drop the byte offset, upper bits wrap.
	assign inst = mem[ridx];     // combinational read.

endmodule

/* verilog/intr_controller.sv */
`timescale 1ns/1ns

module intr_controller (
	input  logic                clk,
	input  logic                rst,
	input  logic                cpu_stall,
	input  intr_pkg::irq_t      irq,
	input  logic                int_enable,
	input  logic                int_ack,
	output intr_pkg::intr_req_t intr_req
);

	intr_pkg::irq_t   pending;  // lines captured so far.
	intr_pkg::irq_t   live;     // pending plus lines raised this cycle.
	logic             enabled;  // controller accepts lines.
	logic             ack_q;    // int_ack one edge ago.
	logic             ack_rise; // first cycle of an acknowledge.
	fetch_pkg::addr_t vector;   // handler of the winning line.

	assign ack_rise = int_ack && !ack_q;

	// lines are only taken while enabled and not busy with an injection.
	assign live = (enabled && !int_ack) ? (pending | irq) : pending;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// priority pick
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_comb begin
		vector = intr_pkg::VECTOR_BASE; // line 0 when nothing is set.
		// walk downwards so the lowest set line is the last one written.
		for (int i = intr_pkg::IRQ_LINES - 1; i >= 0; i--) begin
			if (live[i]) begin
				vector = intr_pkg::VECTOR_BASE
					+ fetch_pkg::addr_t'(i) * intr_pkg::VECTOR_STRIDE;
			end
		end
	end

	assign intr_req.req    = enabled && (|live); // something to inject.
	assign intr_req.vector = vector;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// pending mask and enable flag
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!cpu_stall) begin
			if (rst) begin
				pending <= '0;   // nothing waiting.
				enabled <= 1'b1; // ready out of reset.
				ack_q   <= 1'b0;
			end else begin
				ack_q <= int_ack;
				if (ack_rise) begin
					pending <= '0;   // request consumed by fetch.
					enabled <= 1'b0; // stay quiet until the handler re-enables.
				end else begin
					if (int_enable) begin
						enabled <= 1'b1; // handler return.
					end
					if (enabled && !int_ack) begin
						pending <= live; // keep lines that came and went.
					end
				end
			end
		end
	end

endmodule

/* verilog/fetch_unit.sv */
`timescale 1ns/1ns

module fetch_unit (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  cpu_stall,
	input  logic                  stall,
	input  fetch_pkg::redirect_t  redirect,
	input  intr_pkg::irq_t        irq,
	input  logic                  int_enable,
	input  logic                  imem_we,
	input  fetch_pkg::imem_idx_t  imem_waddr,
	input  fetch_pkg::inst_t      imem_wdata,
	output fetch_pkg::fetch_out_t fetch_out,
	output logic                  int_ack,
	output logic                  int_flush
);

	fetch_pkg::addr_t      pc;        // current fetch address.
	fetch_pkg::inst_t      inst;      // word at pc.
	intr_pkg::intr_req_t   intr_req;  // request and handler vector.
	fetch_pkg::pc_sel_t    pc_sel;    // sequencer action.
	fetch_pkg::latch_sel_t latch_sel; // latch action.

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// control
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	fetch_control u_control (
		.clk(clk), .rst(rst), .cpu_stall(cpu_stall), .stall(stall),
		.redirect(redirect), .intr_req(intr_req),
		.pc_sel(pc_sel), .latch_sel(latch_sel),
		.int_ack(int_ack), .int_flush(int_flush)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// datapath
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	pc_sequencer u_pc (
		.clk(clk), .rst(rst), .cpu_stall(cpu_stall), .pc_sel(pc_sel),
		.redirect(redirect), .vector(intr_req.vector), .pc(pc)
	);

	inst_memory u_imem (
		.clk(clk), .we(imem_we), .waddr(imem_waddr), .wdata(imem_wdata),
		.pc(pc), .inst(inst)
	);

	fetch_latch u_latch (
		.clk(clk), .rst(rst), .cpu_stall(cpu_stall), .latch_sel(latch_sel),
		.pc(pc), .inst(inst), .fetch_out(fetch_out)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// interrupts
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	intr_controller u_intc (
		.clk(clk), .rst(rst), .cpu_stall(cpu_stall), .irq(irq),
		.int_enable(int_enable), .int_ack(int_ack), .intr_req(intr_req)
	);

endmodule

/* sim/fetch_unit_tb.sv */
`timescale 1ns/1ns

module fetch_unit_tb;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// timing and run length
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam int CLK_HALF     = 50;           // 100 ns period.
	localparam int CLK_PERIOD   = 2 * CLK_HALF;
	localparam int DRIVE_DELAY  = 5;            // inputs change after the edge.
	localparam int RESET_CYCLES = 10;
	localparam int LOAD_CYCLES  = fetch_pkg::IMEM_WORDS; // one word per edge.
	localparam int SEQ_CYCLES   = 16;
	localparam int STALL_LEN    = 16;           // stall test, rounded up.
	localparam int REDIRECT_LEN = 24;
	localparam int INTR_LEN     = 16;
	localparam int SLOT_LEN     = 20;
	localparam int RUN_CYCLES   = RESET_CYCLES + LOAD_CYCLES + SEQ_CYCLES + STALL_LEN
		+ REDIRECT_LEN + INTR_LEN + SLOT_LEN;
	localparam int WATCHDOG_NS  = 2 * RUN_CYCLES * CLK_PERIOD; // twice the expected run.
	localparam logic [31:0] LFSR_SEED = 32'h7556_e358;
	localparam logic [31:0] LFSR_MASK = 32'h8020_0003; // x^32 + x^22 + x^2 + x + 1.

	logic                  clk;
	logic                  rst;
	logic                  cpu_stall;
	logic                  stall;
	fetch_pkg::redirect_t  redirect;
	intr_pkg::irq_t        irq;
	logic                  int_enable;
	logic                  imem_we;
	fetch_pkg::imem_idx_t  imem_waddr;
	fetch_pkg::inst_t      imem_wdata;
	fetch_pkg::fetch_out_t fetch_out;
	logic                  int_ack;
	logic                  int_flush;

	fetch_pkg::inst_t model [fetch_pkg::IMEM_WORDS]; // expected memory contents.
	fetch_pkg::addr_t pc_exp;                         // address the DUT fetches next.
	logic [31:0]      lfsr_state;

	fetch_unit UUT (
		.clk(clk), .rst(rst), .cpu_stall(cpu_stall), .stall(stall),
		.redirect(redirect), .irq(irq), .int_enable(int_enable),
		.imem_we(imem_we), .imem_waddr(imem_waddr), .imem_wdata(imem_wdata),
		.fetch_out(fetch_out), .int_ack(int_ack), .int_flush(int_flush)
	);

	initial clk = 1'b0;
	always #(CLK_HALF) clk = ~clk;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// helpers
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		logic [31:0] nxt;
		nxt = state >> 1;                // galois form shifts right.
		if (state[0]) begin
			nxt = nxt ^ LFSR_MASK;       // feedback taps.
		end
		return nxt;
	endfunction

	function automatic fetch_pkg::inst_t word_at(input fetch_pkg::addr_t addr);
		return model[addr[9:2]]; // upper address bits wrap.
	endfunction

	task automatic fail_run;
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic step_clock;
		@(posedge clk);
		#(DRIVE_DELAY); // registers have settled so inputs may change.
	endtask

	task automatic expect_fetch(input fetch_pkg::addr_t exp_pc, input fetch_pkg::inst_t exp_inst);
		assert (fetch_out.pc == exp_pc) else begin
			$display("[ERROR] fetch_out.pc: got %h, expected %h", fetch_out.pc, exp_pc);
			fail_run();
		end
		assert (fetch_out.inst == exp_inst) else begin
			$display("[ERROR] fetch_out.inst: got %h, expected %h", fetch_out.inst, exp_inst);
			fail_run();
		end
	endtask

	task automatic expect_flag(input string name, input logic got, input logic exp);
		assert (got === exp) else begin
			$display("[ERROR] %s: got %h, expected %h", name, got, exp);
			fail_run();
		end
	endtask

	// one plain advance moves the word at pc_exp into the latch.
	task automatic fetch_in_order;
		step_clock();
		expect_fetch(pc_exp, word_at(pc_exp));
		expect_flag("int_ack", int_ack, 1'b0);
		pc_exp = pc_exp + fetch_pkg::PC_STEP;
	endtask

	// memory words come from the lfsr with one step per bit.
	task automatic load_program;
		fetch_pkg::inst_t w;
		for (int i = 0; i < fetch_pkg::IMEM_WORDS; i++) begin
			w = '0;
			for (int b = 0; b < 32; b++) begin
				w = {w[30:0], lfsr_state[0]};
				lfsr_state = lfsr_next(lfsr_state);
			end
			model[i]   = w;
			imem_we    = 1'b1;
			imem_waddr = fetch_pkg::imem_idx_t'(i);
			imem_wdata = w;
			step_clock(); // written on this edge.
		end
		imem_we = 1'b0;
	endtask

	// the request is visible now and ack_now is high when coming from WAIT.
	task automatic inject_sequence(input int line, input logic ack_now);
		fetch_pkg::addr_t vec;
		vec = intr_pkg::VECTOR_BASE + fetch_pkg::addr_t'(line) * intr_pkg::VECTOR_STRIDE;
		#1; // let the new inputs settle.
		expect_flag("int_flush", int_flush, 1'b1);
		expect_flag("int_ack", int_ack, ack_now);
		step_clock();
		expect_fetch('0, fetch_pkg::TRAP_INST); // trap with pc 0.
		expect_flag("int_ack", int_ack, 1'b1);
		expect_flag("int_flush", int_flush, 1'b0);
		irq = '0;
		step_clock();
		expect_fetch('0, fetch_pkg::NOP_INST);  // trap delay slot.
		expect_flag("int_ack", int_ack, 1'b1);
		expect_flag("int_flush", int_flush, 1'b0);
		step_clock();
		expect_fetch(vec, word_at(vec));        // first handler word.
		expect_flag("int_ack", int_ack, 1'b0);
		pc_exp = vec + fetch_pkg::PC_STEP;
	endtask

	task automatic reenable;
		int_enable = 1'b1; // handler return.
		fetch_in_order();
		int_enable = 1'b0;
	endtask

	task automatic redirect_once(input logic br, input logic jp, input fetch_pkg::addr_t b_addr,
		input fetch_pkg::addr_t j_addr, input logic hold);
		fetch_pkg::addr_t target;
		target = br ? b_addr : j_addr; // branch wins over jump.
		stall           = hold;
		redirect.branch = br;
		redirect.jump   = jp;
		redirect.b_addr = b_addr;
		redirect.j_addr = j_addr;
		step_clock();
		expect_fetch('0, '0); // bubble.
		redirect = '0;
		if (hold) begin
			repeat (2) begin
				step_clock();
				expect_fetch('0, '0); // stall keeps the bubble.
			end
			stall = 1'b0;
		end
		pc_exp = target;
		fetch_in_order();
		fetch_in_order();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// tests
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	task automatic sequential_fetch;
		repeat (SEQ_CYCLES) begin
			fetch_in_order();
			expect_flag("int_flush", int_flush, 1'b0);
		end
	endtask

	task automatic stall_hold;
		fetch_pkg::fetch_out_t held;
		fetch_in_order();
		held  = fetch_out;
		stall = 1'b1; // decode back pressure.
		repeat (4) begin
			step_clock();
			expect_fetch(held.pc, held.inst);
		end
		stall = 1'b0;
		fetch_in_order();
		held      = fetch_out;
		cpu_stall = 1'b1; // whole unit frozen.
		repeat (4) begin
			step_clock();
			expect_fetch(held.pc, held.inst);
			expect_flag("int_ack", int_ack, 1'b0);
		end
		cpu_stall = 1'b0;
		fetch_in_order();
		fetch_in_order();
	endtask

	task automatic redirect_paths;
		redirect_once(1'b1, 1'b0, 32'h0000_0040, 32'h0000_0200, 1'b0); // branch.
		redirect_once(1'b0, 1'b1, 32'h0000_0300, 32'h0000_0088, 1'b0); // jump.
		redirect_once(1'b1, 1'b1, 32'h0000_1040, 32'h0000_0010, 1'b0); // both with a wrapping target.
		redirect_once(1'b1, 1'b0, 32'h0000_00c0, 32'h0000_0000, 1'b1); // under stall.
	endtask

	task automatic interrupt_injection;
		irq = 4'b0100;
		inject_sequence(2, 1'b0);
		fetch_in_order();
		reenable();
		irq = 4'b1010; // lower line wins.
		inject_sequence(1, 1'b0);
		fetch_in_order();
		reenable();
	endtask

	task automatic delay_slot_and_reenable;
		irq             = 4'b0001;
		redirect.branch = 1'b1;
		redirect.b_addr = 32'h0000_0080;
		#1;
		expect_flag("int_flush", int_flush, 1'b0); // waits for the slot.
		expect_flag("int_ack", int_ack, 1'b0);
		step_clock();
		expect_fetch('0, '0);
		redirect = '0;
		irq      = '0;
		inject_sequence(0, 1'b1);
		fetch_in_order();
		irq = 4'b1000; // controller is disabled now.
		#1;
		expect_flag("int_flush", int_flush, 1'b0);
		repeat (3) begin
			fetch_in_order();
			expect_flag("int_flush", int_flush, 1'b0);
		end
		int_enable = 1'b1;
		fetch_in_order();
		int_enable = 1'b0;
		inject_sequence(3, 1'b0);
		fetch_in_order();
		reenable();
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// main sequence
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		lfsr_state = LFSR_SEED;
		pc_exp     = '0;
		rst        = 1'b1;
		cpu_stall  = 1'b0;
		stall      = 1'b0;
		redirect   = '0;
		irq        = '0;
		int_enable = 1'b0;
		imem_we    = 1'b0;
		imem_waddr = '0;
		imem_wdata = '0;
		repeat (RESET_CYCLES) step_clock();
		rst       = 1'b0;
		cpu_stall = 1'b1; // hold the core while the program goes in.
		expect_fetch('0, '0);
		expect_flag("int_ack", int_ack, 1'b0);
		expect_flag("int_flush", int_flush, 1'b0);
		load_program();
		cpu_stall = 1'b0;
		sequential_fetch();
		stall_hold();
		redirect_paths();
		interrupt_injection();
		delay_slot_and_reenable();
		$display("TESTBENCH PASSED");
		$finish;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		fail_run();
	end

endmodule

/* fetch_unit.f */
verilog/fetch_pkg.sv
verilog/intr_pkg.sv
verilog/fetch_control.sv
verilog/pc_sequencer.sv
verilog/fetch_latch.sv
verilog/inst_memory.sv
verilog/intr_controller.sv
verilog/fetch_unit.sv
sim/fetch_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the fetch unit testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--top-module fetch_unit_tb \
	-f fetch_unit.f \
	-o fetch_unit_sim

# the simulator exits non-zero on $fatal, keep its output for the search
out=$(./obj_dir/fetch_unit_sim || true)
echo "$out"

if echo "$out" | grep -q "TESTBENCH PASSED"; then
	exit 0
else
	exit 1
fi
